//--- la32_dec.f
hw/la32_dec_pkg.sv
hw/fifo_if.sv
hw/ir_fifo.sv
hw/inst_decoder.sv
hw/decode_stage.sv
hw/la32_dec_top.sv
verif/tb_clkgen.sv
verif/la32_dec_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= la32_dec_tb
RTL_TOP   ?= la32_dec_top
FLIST     ?= la32_dec.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "Simulation gave no result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) \
		hw/la32_dec_pkg.sv hw/fifo_if.sv hw/ir_fifo.sv hw/inst_decoder.sv \
		hw/decode_stage.sv hw/la32_dec_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/la32_dec_tb.sv
`timescale 1ns/1ps

module la32_dec_tb
    import la32_dec_pkg::*;
;

    logic              clk;
    logic              arst_n;
    logic              in_push;
    logic [xlen-1:0]   in_pc;
    logic [31:0]       in_ir;
    logic              in_full;
    logic              out_pop;
    logic              out_valid;
    logic [xlen-1:0]   out_pc;
    ctrl_t             out_ctrl;
    logic [reg_w-1:0]  out_rk;
    logic [reg_w-1:0]  out_rj;
    logic [reg_w-1:0]  out_rd;
    logic [xlen-1:0]   out_imm;
    logic [excp_w-1:0] out_excp_arg;
    logic              out_ine;

    logic [31:0] ir_q[$];                       // Stimulus words
    dec_pkt_t    exp_q[$];                      // Expected records
    logic [31:0] rnd_state;
    int          cycle;
    int          push_cycle;
    int          n_checks;
    int          n_errors;

    tb_clkgen tb_clkgen_i (.clk(clk), .arst_n(arst_n));

    la32_dec_top la32_dec_top_i (.*);

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Flags in ctrl order pc_src, src1, src2, reg_write, mem_write, mem_read
    function automatic ctrl_t ctl(alu_op_t op, unit_t u, int st, logic [5:0] f);
        ctrl_t c;
        c.alu_op    = op;
        c.pc_src    = {1'b0, f[5]};
        c.alu_src1  = {1'b0, f[4]};
        c.alu_src2  = {1'b0, f[3]};
        c.unit      = u;
        c.subtype   = st[4:0];
        c.reg_write = f[2];
        c.mem_write = f[1];
        c.mem_read  = f[0];
        return c;
    endfunction

    task automatic add_row(logic [31:0] ir, ctrl_t c, int rk, int rj, int rd,
                           logic [31:0] imm, logic [15:0] ex, logic ine);
        dec_pkt_t e;
        e.pc       = 32'(exp_q.size() * 4);
        e.ctrl     = c;
        e.rk       = rk[4:0];
        e.rj       = rj[4:0];
        e.rd       = rd[4:0];
        e.imm      = imm;
        e.excp_arg = ex;
        e.ine      = ine;
        ir_q.push_back(ir);
        exp_q.push_back(e);
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic build_table();
        add_row({17'h00020,5'd5,5'd4,5'd3}, ctl(alu_add, unit_alu, 0, 6'b000100), 5, 4, 3, 0, 0, 0);
        add_row({17'h00022,5'd5,5'd4,5'd3}, ctl(alu_sub, unit_alu, 0, 6'b000100), 5, 4, 3, 0, 0, 0);
        add_row({17'h00025,5'd5,5'd4,5'd3}, ctl(alu_sltu, unit_alu, 0, 6'b000100), 5, 4, 3, 0, 0, 0);
        add_row({17'h00029,5'd5,5'd4,5'd3}, ctl(alu_and, unit_alu, 0, 6'b000100), 5, 4, 3, 0, 0, 0);
        add_row({17'h0002b,5'd5,5'd4,5'd3}, ctl(alu_xor, unit_alu, 0, 6'b000100), 5, 4, 3, 0, 0, 0);
        add_row({17'h0002e,5'd5,5'd4,5'd3}, ctl(alu_sll, unit_alu, 0, 6'b000100), 5, 4, 3, 0, 0, 0);
        add_row({17'h00038,5'd5,5'd4,5'd3}, ctl(alu_and, unit_mul, 0, 6'b000100), 5, 4, 3, 0, 0, 0);
        add_row({17'h0003a,5'd5,5'd4,5'd3}, ctl(alu_and, unit_mul, 2, 6'b000100), 5, 4, 3, 0, 0, 0);
        add_row({17'h00040,5'd5,5'd4,5'd3}, ctl(alu_and, unit_div, 0, 6'b000100), 5, 4, 3, 0, 0, 0);
        add_row({17'h00043,5'd5,5'd4,5'd3}, ctl(alu_and, unit_div, 3, 6'b000100), 5, 4, 3, 0, 0, 0);
        add_row({17'h00081,5'd31,5'd4,5'd3}, ctl(alu_sll, unit_alu, 0, 6'b001100), 0, 4, 3, 31, 0, 0);
        add_row({17'h00091,5'd7,5'd4,5'd3}, ctl(alu_sra, unit_alu, 0, 6'b001100), 0, 4, 3, 7, 0, 0);
        add_row({10'h00a,12'h7ff,5'd4,5'd3}, ctl(alu_add, unit_alu, 0, 6'b001100), 0, 4, 3,
                32'h000007ff, 0, 0);
        add_row({10'h00a,12'h800,5'd4,5'd3}, ctl(alu_add, unit_alu, 0, 6'b001100), 0, 4, 3,
                32'hfffff800, 0, 0);
        add_row({10'h008,12'hfff,5'd4,5'd3}, ctl(alu_slt, unit_alu, 0, 6'b001100), 0, 4, 3,
                32'hffffffff, 0, 0);
        add_row({10'h00d,12'hfff,5'd4,5'd3}, ctl(alu_and, unit_alu, 0, 6'b001100), 0, 4, 3,
                32'h00000fff, 0, 0);
        add_row({10'h00f,12'h800,5'd4,5'd3}, ctl(alu_xor, unit_alu, 0, 6'b001100), 0, 4, 3,
                32'h00000800, 0, 0);
        add_row({7'h0a,20'h80001,5'd3}, ctl(alu_pass_b, unit_alu, 0, 6'b001100), 0, 0, 3,
                32'h80001000, 0, 0);
        add_row({7'h0e,20'h00010,5'd3}, ctl(alu_add, unit_alu, 0, 6'b011100), 0, 0, 3,
                32'h00010000, 0, 0);
        add_row({10'h0a2,12'hff8,5'd4,5'd3}, ctl(alu_and, unit_dcache, 2, 6'b000101), 0, 4, 3,
                32'hfffffff8, 0, 0);
        add_row({10'h0a8,12'h010,5'd4,5'd3}, ctl(alu_and, unit_dcache, 6, 6'b000101), 0, 4, 3,
                32'h10, 0, 0);
        add_row({10'h0a6,12'h004,5'd4,5'd3}, ctl(alu_and, unit_dcache, 5, 6'b000010), 0, 4, 3, 4, 0, 0);
        add_row({10'h0a4,12'hffc,5'd4,5'd3}, ctl(alu_and, unit_dcache, 3, 6'b000010), 0, 4, 3,
                32'hfffffffc, 0, 0);
        add_row({8'h20,14'h2000,5'd4,5'd3}, ctl(alu_and, unit_atomic, 0, 6'b000101), 0, 4, 3,
                32'hffffe000, 0, 0);
        add_row({8'h21,14'h0010,5'd4,5'd3}, ctl(alu_and, unit_atomic, 1, 6'b000010), 0, 4, 3,
                32'h10, 0, 0);
        add_row({6'h16,16'hfffe,5'd4,5'd3}, ctl(alu_and, unit_br, 1, 6'b100000), 0, 4, 3,
                32'hfffffff8, 0, 0);
        add_row({6'h17,16'h0004,5'd4,5'd3}, ctl(alu_and, unit_br, 2, 6'b100000), 0, 4, 3, 32'h10, 0, 0);
        add_row({6'h14,16'h0001,10'h3ff}, ctl(alu_and, unit_br, 0, 6'b100000), 0, 0, 0,
                32'hfffc0004, 0, 0);
        add_row({6'h15,16'h0010,10'h000}, ctl(alu_add4, unit_link, 1, 6'b110100), 0, 0, 1,
                32'h40, 0, 0);
        add_row({6'h13,16'h0002,5'd4,5'd3}, ctl(alu_add4, unit_link, 0, 6'b110100), 0, 4, 3, 8, 0, 0);
        add_row({8'h04,14'h0181,5'd0,5'd3}, ctl(alu_and, unit_priv, 8, 6'b000100), 0, 0, 3, 0,
                16'h0181, 0);
        add_row({8'h04,14'h3fff,5'd1,5'd3}, ctl(alu_and, unit_priv, 9, 6'b000000), 0, 0, 3, 0,
                16'h3fff, 0);
        add_row({8'h04,14'h0005,5'd4,5'd3}, ctl(alu_and, unit_priv, 10, 6'b000100), 0, 0, 3, 0, 5, 0);
        add_row({17'h00c90,15'h3800}, ctl(alu_and, unit_priv, 6, 6'b000000), 0, 0, 0, 0, 0, 0);
        add_row({17'h00c91,15'h0123}, ctl(alu_and, unit_priv, 7, 6'b000000), 0, 0, 0, 0, 16'h0123, 0);
        add_row({17'h00054,15'h0005}, ctl(alu_and, unit_priv, 11, 6'b000000), 0, 0, 0, 0, 5, 0);
        add_row({17'h00056,15'h7fff}, ctl(alu_and, unit_priv, 12, 6'b000000), 0, 0, 0, 0, 16'h7fff, 0);
        add_row({17'h0,5'b11000,5'd4,5'd0}, ctl(alu_and, unit_cnt, 0, 6'b000000), 0, 4, 0, 0, 0, 0);
        add_row({17'h0,5'b11000,5'd0,5'd3}, ctl(alu_and, unit_cnt, 1, 6'b000000), 0, 0, 3, 0, 0, 0);
        add_row({17'h0,5'b11001,5'd0,5'd3}, ctl(alu_and, unit_cnt, 2, 6'b000000), 0, 0, 3, 0, 0, 0);
        add_row({10'h018,12'h004,5'd4,5'd9}, ctl(alu_and, unit_priv, 0, 6'b000000), 0, 4, 0, 4, 9, 0);
        add_row({17'h070e5,15'h0}, ctl(alu_and, unit_dcache, 8, 6'b000000), 0, 0, 0, 0, 0, 0);
        add_row({10'h0ab,12'h010,5'd4,5'd3}, '0, 0, 0, 0, 0, 0, 0);   // PRELD
        add_row({17'h070e4,15'h0}, '0, 0, 0, 0, 0, 0, 0);             // DBAR
        add_row(32'hffffffff, '0, 0, 0, 0, 0, 0, 1);
        add_row(32'h00000000, '0, 0, 0, 0, 0, 0, 1);
        add_row({17'h00c90,15'h2800}, '0, 0, 0, 0, 0, 0, 1);          // TLBSRCH
    endtask

    task automatic produce();
        int i;
        i = 0;
        while (i < ir_q.size())
        begin
            @(posedge clk);
            #10;
            in_push = !in_full;
            if (!in_full)
            begin
                in_pc = 32'(i * 4);
                in_ir = ir_q[i];
                if (i == 0)
                    push_cycle = cycle;
                i++;
            end
        end
        @(posedge clk);
        #10;
        in_push = 1'b0;
    endtask

    task automatic consume();
        int k;
        k = 0;
        while (k < exp_q.size())
        begin
            @(posedge clk);
            #10;
            out_pop   = 1'b0;
            rnd_state = xorshift(rnd_state);
            if (out_valid && (k == 0 || rnd_state[0]))
            begin
                if (k == 0)
                    check("first entry latency", 32'(cycle - push_cycle), 32'd2);
                check("out_pc", out_pc, exp_q[k].pc);
                check("out_ctrl", 32'(out_ctrl), 32'(exp_q[k].ctrl));
                check("out_rk", 32'(out_rk), 32'(exp_q[k].rk));
                check("out_rj", 32'(out_rj), 32'(exp_q[k].rj));
                check("out_rd", 32'(out_rd), 32'(exp_q[k].rd));
                check("out_imm", out_imm, exp_q[k].imm);
                check("out_excp_arg", 32'(out_excp_arg), 32'(exp_q[k].excp_arg));
                check("out_ine", 32'(out_ine), 32'(exp_q[k].ine));
                out_pop = 1'b1;
                k++;
            end
        end
        @(posedge clk);
        #10;
        out_pop = 1'b0;
        check("out_valid after last entry", 32'(out_valid), 32'd0);
    endtask

    initial
    begin
        in_push    = 1'b0;
        in_pc      = '0;
        in_ir      = '0;
        out_pop    = 1'b0;
        cycle      = 0;
        push_cycle = 0;
        n_checks   = 0;
        n_errors   = 0;
        rnd_state  = 32'h1fe5fad7;
        build_table();
        fork
            begin
                #((8 + ir_q.size() * 20) * 100ns);
                $display("Timeout: the queues did not deliver every entry in time");
                $display(">>> FAIL");
                $finish;
            end
        join_none
        wait (arst_n);
        @(posedge clk);
        #10;
        check("out_valid after reset", 32'(out_valid), 32'd0);
        check("in_full after reset", 32'(in_full), 32'd0);
        fork
            produce();
            consume();
        join
        $display("Checks: %0d, mismatches: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

    localparam realtime half_period = 50ns;     // 100 ns clock
    localparam int      reset_cycles = 8;

    initial
    begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n = 1'b1;
    end

    always #(half_period) clk = ~clk;

endmodule

//--- hw/la32_dec_top.sv
`timescale 1ns/1ps

module la32_dec_top
    import la32_dec_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_push,
    input  logic [xlen-1:0]   in_pc,
    input  logic [31:0]       in_ir,
    output logic              in_full,
    input  logic              out_pop,
    output logic              out_valid,
    output logic [xlen-1:0]   out_pc,
    output ctrl_t             out_ctrl,
    output logic [reg_w-1:0]  out_rk,
    output logic [reg_w-1:0]  out_rj,
    output logic [reg_w-1:0]  out_rd,
    output logic [xlen-1:0]   out_imm,
    output logic [excp_w-1:0] out_excp_arg,
    output logic              out_ine
);

    fifo_if #(.payload_t(fetch_pkt_t)) fetch_bus ();
    fifo_if #(.payload_t(dec_pkt_t))   issue_bus ();

    assign fetch_bus.push      = in_push;
    assign fetch_bus.push_data = '{pc: in_pc, ir: in_ir};
    assign in_full             = fetch_bus.full;

    ir_fifo #(
        .payload_t (fetch_pkt_t),
        .depth     (fetch_depth)
    ) fetch_q (
        .clk    (clk),
        .arst_n (arst_n),
        .q      (fetch_bus.queue)
    );

    decode_stage decode_stage_i (
        .clk    (clk),
        .arst_n (arst_n),
        .fetch  (fetch_bus.consumer),
        .issue  (issue_bus.producer)
    );

    ir_fifo #(
        .payload_t (dec_pkt_t),
        .depth     (issue_depth)
    ) issue_q (
        .clk    (clk),
        .arst_n (arst_n),
        .q      (issue_bus.queue)
    );

    assign issue_bus.pop = out_pop;
    assign out_valid     = !issue_bus.empty;        // Head entry is valid

    assign out_pc       = issue_bus.pop_data.pc;
    assign out_ctrl     = issue_bus.pop_data.ctrl;
    assign out_rk       = issue_bus.pop_data.rk;
    assign out_rj       = issue_bus.pop_data.rj;
    assign out_rd       = issue_bus.pop_data.rd;
    assign out_imm      = issue_bus.pop_data.imm;
    assign out_excp_arg = issue_bus.pop_data.excp_arg;
    assign out_ine      = issue_bus.pop_data.ine;

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import la32_dec_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    fifo_if.consumer fetch,
    fifo_if.producer issue
);

    logic     xfer;
    dec_pkt_t dec;

    // One entry moves per cycle when both queues allow it
    assign xfer = !fetch.empty && !issue.full;

    inst_decoder inst_decoder_i (
        .ir  (fetch.pop_data.ir),
        .pc  (fetch.pop_data.pc),
        .dec (dec)
    );

    assign fetch.pop       = xfer;
    assign issue.push      = xfer;
    assign issue.push_data = dec;                   // Carries the fetch pc along

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) issue.push |-> !issue.full
    ) else $error("decode_stage push into full issue queue");

endmodule

//--- hw/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import la32_dec_pkg::*;
(
    input  logic [31:0]     ir,
    input  logic [xlen-1:0] pc,
    output dec_pkt_t        dec
);

    typedef struct packed {
        fmt_t  fmt;
        ctrl_t ctrl;
    } row_t;

    row_t              r;
    logic              ine;
    logic              nop;                     // PRELD and DBAR
    logic              use_rj;
    logic              use_rd;
    logic [xlen-1:0]   imm;
    logic [excp_w-1:0] excp_arg;

    function automatic row_t row(alu_op_t op, unit_t u, logic [subtype_w-1:0] st,
                                 fmt_t f, logic [5:0] fl);
        row_t x;
        x.fmt            = f;
        x.ctrl.alu_op    = op;
        x.ctrl.pc_src    = {1'b0, fl[5]};
        x.ctrl.alu_src1  = {1'b0, fl[4]};
        x.ctrl.alu_src2  = {1'b0, fl[3]};
        x.ctrl.unit      = u;
        x.ctrl.subtype   = st;
        x.ctrl.reg_write = fl[2];
        x.ctrl.mem_write = fl[1];
        x.ctrl.mem_read  = fl[0];
        return x;
    endfunction

    // Fields of ir[31:15] grouped as 31:26, 25:22 and 21:15
    always_comb
    begin
        r   = '0;
        ine = 1'b0;
        nop = 1'b0;
        casez (ir[31:15])
            17'b000000_0000_0000000:
                if (ir[14:11] != 4'b1100)
                    ine = 1'b1;
                else if (!ir[10] && ir[9:5] != 5'd0)
                    r = row(alu_and, unit_cnt, 5'd0, fmt_rj, fl_none);     // RDCNTID.W
                else if (!ir[10] && ir[4:0] != 5'd0)
                    r = row(alu_and, unit_cnt, 5'd1, fmt_rd, fl_none);     // RDCNTVL.W
                else if (ir[10] && ir[9:5] == 5'd0)
                    r = row(alu_and, unit_cnt, 5'd2, fmt_rd, fl_none);     // RDCNTVH.W
                else
                    ine = 1'b1;
            17'b000000_0000_0100000: r = row(alu_add, unit_alu, 5'd0, fmt_3r, fl_rw);  // ADD.W
            17'b000000_0000_0100010: r = row(alu_sub, unit_alu, 5'd0, fmt_3r, fl_rw);  // SUB.W
            17'b000000_0000_0100100: r = row(alu_slt, unit_alu, 5'd0, fmt_3r, fl_rw);
            17'b000000_0000_0100101: r = row(alu_sltu, unit_alu, 5'd0, fmt_3r, fl_rw);
            17'b000000_0000_0101000: r = row(alu_nor, unit_alu, 5'd0, fmt_3r, fl_rw);
            17'b000000_0000_0101001: r = row(alu_and, unit_alu, 5'd0, fmt_3r, fl_rw);
            17'b000000_0000_0101010: r = row(alu_or, unit_alu, 5'd0, fmt_3r, fl_rw);
            17'b000000_0000_0101011: r = row(alu_xor, unit_alu, 5'd0, fmt_3r, fl_rw);
            17'b000000_0000_0101110: r = row(alu_sll, unit_alu, 5'd0, fmt_3r, fl_rw);  // SLL.W
            17'b000000_0000_0101111: r = row(alu_srl, unit_alu, 5'd0, fmt_3r, fl_rw);  // SRL.W
            17'b000000_0000_0110000: r = row(alu_sra, unit_alu, 5'd0, fmt_3r, fl_rw);  // SRA.W
            17'b000000_0000_0111000: r = row(alu_and, unit_mul, 5'd0, fmt_3r, fl_rw);  // MUL.W
            17'b000000_0000_0111001: r = row(alu_and, unit_mul, 5'd1, fmt_3r, fl_rw);  // MULH.W
            17'b000000_0000_0111010: r = row(alu_and, unit_mul, 5'd2, fmt_3r, fl_rw);  // MULH.WU
            17'b000000_0000_1000000: r = row(alu_and, unit_div, 5'd0, fmt_3r, fl_rw);  // DIV.W
            17'b000000_0000_1000001: r = row(alu_and, unit_div, 5'd1, fmt_3r, fl_rw);  // MOD.W
            17'b000000_0000_1000010: r = row(alu_and, unit_div, 5'd2, fmt_3r, fl_rw);  // DIV.WU
            17'b000000_0000_1000011: r = row(alu_and, unit_div, 5'd3, fmt_3r, fl_rw);  // MOD.WU
            17'b000000_0000_1010100: r = row(alu_and, unit_priv, 5'd11, fmt_code, fl_none);
            17'b000000_0000_1010110: r = row(alu_and, unit_priv, 5'd12, fmt_code, fl_none);
            17'b000000_0001_0000001: r = row(alu_sll, unit_alu, 5'd0, fmt_ui5, fl_rwi);  // SLLI
            17'b000000_0001_0001001: r = row(alu_srl, unit_alu, 5'd0, fmt_ui5, fl_rwi);  // SRLI
            17'b000000_0001_0010001: r = row(alu_sra, unit_alu, 5'd0, fmt_ui5, fl_rwi);  // SRAI
            17'b000000_1000_???????: r = row(alu_slt, unit_alu, 5'd0, fmt_si12, fl_rwi);
            17'b000000_1001_???????: r = row(alu_sltu, unit_alu, 5'd0, fmt_si12, fl_rwi);
            17'b000000_1010_???????: r = row(alu_add, unit_alu, 5'd0, fmt_si12, fl_rwi);
            17'b000000_1101_???????: r = row(alu_and, unit_alu, 5'd0, fmt_ui12, fl_rwi);
            17'b000000_1110_???????: r = row(alu_or, unit_alu, 5'd0, fmt_ui12, fl_rwi);
            17'b000000_1111_???????: r = row(alu_xor, unit_alu, 5'd0, fmt_ui12, fl_rwi);
            17'b000001_00??_???????:                // CSR ops, rj selects the kind
                if (ir[9:5] == 5'd0)
                    r = row(alu_and, unit_priv, 5'd8, fmt_csr, fl_rw);     // CSRRD
                else if (ir[9:5] == 5'd1)
                    r = row(alu_and, unit_priv, 5'd9, fmt_csr, fl_none);   // CSRWR
                else
                    r = row(alu_and, unit_priv, 5'd10, fmt_csr, fl_rw);    // CSRXCHG
            17'b000001_1000_???????: r = row(alu_and, unit_priv, 5'd0, fmt_cacop, fl_none);
            17'b000001_1001_0010000:
                if (ir[14:0] == 15'h3800)
                    r = row(alu_and, unit_priv, 5'd6, fmt_none, fl_none);  // ERTN
                else
                    ine = 1'b1;                     // TLB ops land here too
            17'b000001_1001_0010001: r = row(alu_and, unit_priv, 5'd7, fmt_code, fl_none);
            17'b000101_0???_???????: r = row(alu_pass_b, unit_alu, 5'd0, fmt_u20, fl_rwi);
            17'b000111_0???_???????: r = row(alu_add, unit_alu, 5'd0, fmt_u20, fl_pcrel);
            17'b001000_00??_???????: r = row(alu_and, unit_atomic, 5'd0, fmt_si14, fl_ld);
            17'b001000_01??_???????: r = row(alu_and, unit_atomic, 5'd1, fmt_si14, fl_st);
            17'b001010_0000_???????: r = row(alu_and, unit_dcache, 5'd0, fmt_si12, fl_ld);
            17'b001010_0001_???????: r = row(alu_and, unit_dcache, 5'd1, fmt_si12, fl_ld);
            17'b001010_0010_???????: r = row(alu_and, unit_dcache, 5'd2, fmt_si12, fl_ld);
            17'b001010_0100_???????: r = row(alu_and, unit_dcache, 5'd3, fmt_si12, fl_st);
            17'b001010_0101_???????: r = row(alu_and, unit_dcache, 5'd4, fmt_si12, fl_st);
            17'b001010_0110_???????: r = row(alu_and, unit_dcache, 5'd5, fmt_si12, fl_st);
            17'b001010_1000_???????: r = row(alu_and, unit_dcache, 5'd6, fmt_si12, fl_ld);
            17'b001010_1001_???????: r = row(alu_and, unit_dcache, 5'd7, fmt_si12, fl_ld);
            17'b001010_1011_???????: nop = 1'b1;    // PRELD
            17'b001110_0001_1100100: nop = 1'b1;    // DBAR
            17'b001110_0001_1100101: r = row(alu_and, unit_dcache, 5'd8, fmt_none, fl_none);
            17'b010011_????_???????: r = row(alu_add4, unit_link, 5'd0, fmt_br16, fl_link);
            17'b010100_????_???????: r = row(alu_and, unit_br, 5'd0, fmt_b26, fl_br);  // B
            17'b010101_????_???????: r = row(alu_add4, unit_link, 5'd1, fmt_bl, fl_link);
            17'b010110_????_???????: r = row(alu_and, unit_br, 5'd1, fmt_br16, fl_br); // BEQ
            17'b010111_????_???????: r = row(alu_and, unit_br, 5'd2, fmt_br16, fl_br); // BNE
            17'b011000_????_???????: r = row(alu_and, unit_br, 5'd3, fmt_br16, fl_br); // BLT
            17'b011001_????_???????: r = row(alu_and, unit_br, 5'd4, fmt_br16, fl_br); // BGE
            17'b011010_????_???????: r = row(alu_and, unit_br, 5'd5, fmt_br16, fl_br); // BLTU
            17'b011011_????_???????: r = row(alu_and, unit_br, 5'd6, fmt_br16, fl_br); // BGEU
            default:
                ine = 1'b1;
        endcase
    end

    always_comb
    begin
        case (r.fmt)
            fmt_ui5:   imm = {27'd0, ir[14:10]};
            fmt_si12,
            fmt_cacop: imm = {{20{ir[21]}}, ir[21:10]};
            fmt_ui12:  imm = {20'd0, ir[21:10]};
            fmt_u20:   imm = {ir[24:5], 12'd0};                         // Upper 20 bits
            fmt_si14:  imm = {{18{ir[23]}}, ir[23:10]};
            fmt_br16:  imm = {{14{ir[25]}}, ir[25:10], 2'b00};
            fmt_b26,
            fmt_bl:    imm = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};   // offs[25:16] in ir[9:0]
            default:   imm = '0;
        endcase
    end

    always_comb
    begin
        case (r.fmt)
            fmt_csr:   excp_arg = {2'b00, ir[23:10]};   // CSR number
            fmt_code:  excp_arg = {1'b0, ir[14:0]};
            fmt_cacop: excp_arg = {11'd0, ir[4:0]};     // Cache op code
            default:   excp_arg = '0;
        endcase
    end

    assign use_rj = r.fmt inside {fmt_3r, fmt_rj, fmt_ui5, fmt_si12, fmt_ui12, fmt_si14,
                                  fmt_br16, fmt_cacop};
    assign use_rd = r.fmt inside {fmt_3r, fmt_rd, fmt_ui5, fmt_si12, fmt_ui12, fmt_u20,
                                  fmt_si14, fmt_br16, fmt_csr};

    assign dec.pc       = pc;
    assign dec.ctrl     = (ine || nop) ? '0 : r.ctrl;
    assign dec.rk       = (r.fmt == fmt_3r) ? ir[14:10] : 5'd0;
    assign dec.rj       = use_rj ? ir[9:5] : 5'd0;
    assign dec.rd       = (r.fmt == fmt_bl) ? 5'd1 : (use_rd ? ir[4:0] : 5'd0);  // BL links r1
    assign dec.imm      = imm;
    assign dec.excp_arg = excp_arg;
    assign dec.ine      = ine;

endmodule

//--- hw/ir_fifo.sv
`timescale 1ns/1ps

module ir_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic  clk,
    input  logic  arst_n,
    fifo_if.queue q
);

    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] cnt_t;

    payload_t mem [depth];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    cnt_t     count;
    logic     do_push;
    logic     do_pop;

    assign q.full  = (count == cnt_t'(depth));
    assign q.empty = (count == '0);

    assign do_push = q.push && !q.full;         // Push into a full queue is dropped
    assign do_pop  = q.pop && !q.empty;

    assign q.pop_data = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= q.push_data;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle, or push and pop together
            endcase
        end
    end

    // The producer on the far side of the bus has to respect full
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) q.push |-> !q.full
    ) else $error("ir_fifo push while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n) q.pop |-> !q.empty
    ) else $error("ir_fifo pop while empty");

endmodule

//--- hw/fifo_if.sv
`timescale 1ns/1ps

interface fifo_if #(
    parameter type payload_t = logic
);

    logic     push;
    payload_t push_data;
    logic     full;
    logic     pop;
    payload_t pop_data;                         // Head entry
    logic     empty;

    modport producer (output push, output push_data, input full);

    modport consumer (output pop, input pop_data, input empty);

    // Storage side of the queue
    modport queue (
        input  push, input  push_data, output full,
        input  pop,  output pop_data,  output empty
    );

endinterface

//--- hw/la32_dec_pkg.sv
package la32_dec_pkg;

    localparam int fetch_depth = 4;             // Fetch queue entries
    localparam int issue_depth = 4;             // Issue queue entries

    localparam int xlen      = 32;
    localparam int reg_w     = 5;               // Register index
    localparam int subtype_w = 5;
    localparam int excp_w    = 16;              // CSR number or exception code

    typedef enum logic [3:0] {
        unit_alu    = 4'd0,
        unit_br     = 4'd1,
        unit_div    = 4'd2,
        unit_priv   = 4'd3,
        unit_mul    = 4'd4,
        unit_dcache = 4'd5,
        unit_atomic = 4'd6,
        unit_cnt    = 4'd7,
        unit_link   = 4'd8                      // ALU writeback plus branch
    } unit_t;

    typedef enum logic [3:0] {
        alu_and    = 4'd0,
        alu_or     = 4'd1,
        alu_nor    = 4'd2,
        alu_xor    = 4'd3,
        alu_add    = 4'd4,
        alu_sub    = 4'd5,
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        alu_sra    = 4'd8,
        alu_slt    = 4'd9,
        alu_sltu   = 4'd10,
        alu_pass_a = 4'd11,
        alu_pass_b = 4'd12,
        alu_add4   = 4'd13                      // Return address
    } alu_op_t;

    // Operand layout of an instruction, picks register fields and immediate
    typedef enum logic [3:0] {
        fmt_none, fmt_3r, fmt_rj, fmt_rd, fmt_ui5, fmt_si12, fmt_ui12, fmt_u20,
        fmt_si14, fmt_br16, fmt_b26, fmt_bl, fmt_csr, fmt_cacop, fmt_code
    } fmt_t;

    // Bit order is branch, src1 pc, src2 imm, reg write, mem write, mem read
    localparam logic [5:0] fl_none  = 6'b000000;
    localparam logic [5:0] fl_rw    = 6'b000100;
    localparam logic [5:0] fl_rwi   = 6'b001100;
    localparam logic [5:0] fl_ld    = 6'b000101;
    localparam logic [5:0] fl_st    = 6'b000010;
    localparam logic [5:0] fl_br    = 6'b100000;
    localparam logic [5:0] fl_link  = 6'b110100;
    localparam logic [5:0] fl_pcrel = 6'b011100;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     ir;
    } fetch_pkt_t;

    typedef struct packed {
        alu_op_t              alu_op;
        logic [1:0]           pc_src;           // 1 for branch target
        logic [1:0]           alu_src1;         // 1 for pc
        logic [1:0]           alu_src2;         // 1 for immediate
        unit_t                unit;
        logic [subtype_w-1:0] subtype;
        logic                 reg_write;
        logic                 mem_write;
        logic                 mem_read;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0]   pc;
        ctrl_t             ctrl;
        logic [reg_w-1:0]  rk;
        logic [reg_w-1:0]  rj;
        logic [reg_w-1:0]  rd;
        logic [xlen-1:0]   imm;
        logic [excp_w-1:0] excp_arg;
        logic              ine;                 // Illegal instruction
    } dec_pkt_t;

endpackage
